/* rtl/dp_pkg.sv */
package dp_pkg;

	////////////////////////////////////////
	// Widths.
	////////////////////////////////////////

	// Wishbone word address and data.
	localparam int WB_AW = 4;
	localparam int WB_DW = 32;
	// Samples per bit per SYSCLK.
	localparam int NIB_W = 4;
	// Two nibbles per training pattern.
	localparam int PAT_W = 8;
	// Refclk edge counter.
	localparam int CNT_W = 10;
	// Refclk select field.
	localparam int REFSEL_W = 4;
	// Bit select, bit number low, channel high.
	localparam int BSEL_BIT_W = 4;
	localparam int BSEL_CH_W = 3;
	localparam int BSEL_W = BSEL_BIT_W + BSEL_CH_W;

	typedef logic [WB_AW-1:0]    wb_addr_t;
	typedef logic [WB_DW-1:0]    wb_data_t;
	typedef logic [PAT_W-1:0]    pattern_t;
	typedef logic [CNT_W-1:0]    refcnt_t;
	typedef logic [BSEL_W-1:0]   bitsel_t;
	typedef logic [REFSEL_W-1:0] refsel_t;

	////////////////////////////////////////
	// Register map.
	////////////////////////////////////////

	localparam wb_addr_t ADDR_DPCTRL     = 4'd0;
	localparam wb_addr_t ADDR_DPTRAINING = 4'd1;
	localparam wb_addr_t ADDR_DPCOUNTER  = 4'd2;
	localparam wb_addr_t ADDR_DPCLKQ     = 4'd3;

	// DPCTRL fields.
	localparam int DPCTRL_PULSE_BIT = 0;
	localparam int DPCTRL_CONT_BIT  = 1;
	// DPTRAINING fields.
	localparam int DPTR_DIS_BIT = 31;
	localparam int DPTR_SEL_LSB = 16;
	localparam int DPTR_PAT_LSB = 0;
	// DPCOUNTER fields.
	localparam int DPCNT_SEL_LSB = 16;
	localparam int DPCNT_CNT_LSB = 0;

endpackage

/* rtl/dp_ctrl_if.sv */
`timescale 1ns/1ns

// Training control down, selected pattern back.
interface dp_train_if import dp_pkg::*; ();
	// Level controls from the register block.
	logic     train_disable;
	bitsel_t  bit_select;
	// Pattern of the selected bit.
	pattern_t pattern;

	modport regs (
		output train_disable,
		output bit_select,
		input  pattern
	);

	modport capture (
		input  train_disable,
		input  bit_select,
		output pattern
	);
endinterface

// VCDL and refclk control down, count and levels back.
interface dp_vcdl_if import dp_pkg::*; #(
	parameter int NUM_REF = 2
) ();
	// Single-cycle strobes.
	logic               vcdl_pulse;
	logic               ref_select_wr;
	// Levels.
	logic               vcdl_enable;
	refsel_t            ref_select;
	// Status from the refclk monitor.
	refcnt_t            ref_count;
	logic [NUM_REF-1:0] ref_q;

	modport regs (
		output vcdl_pulse,
		output vcdl_enable,
		output ref_select,
		output ref_select_wr,
		input  ref_count,
		input  ref_q
	);

	modport clk (
		input  vcdl_pulse,
		input  vcdl_enable,
		input  ref_select,
		input  ref_select_wr,
		output ref_count,
		output ref_q
	);
endinterface

/* rtl/dp_regs.sv */
`timescale 1ns/1ns

module dp_regs import dp_pkg::*; #(
	parameter int NUM_CH  = 2,
	parameter int NUM_BIT = 12,
	parameter int NUM_REF = 2
) (
	input  logic     SYSCLK,
	input  logic     arst_n_i,
	input  logic     wb_cyc_i,
	input  logic     wb_stb_i,
	input  logic     wb_we_i,
	input  wb_addr_t wb_adr_i,
	input  wb_data_t wb_dat_i,
	output wb_data_t wb_dat_o,
	output logic     wb_ack_o,
	dp_train_if.regs train,
	dp_vcdl_if.regs  vcdl
);

	// Channel and bit count must fit the 7-bit select.
	if (NUM_CH > (1 << BSEL_CH_W) || NUM_BIT > (1 << BSEL_BIT_W)) begin : g_bsel_chk
		$error("dp_regs: NUM_CH or NUM_BIT exceeds bit select range");
	end
	// Refclks must fit the select field and DPCLKQ.
	if (NUM_REF > (1 << REFSEL_W) || NUM_REF > WB_DW) begin : g_ref_chk
		$error("dp_regs: NUM_REF exceeds refclk select range");
	end

	logic     req;
	logic     acc;
	logic     wr_stb;
	logic     ack_q;
	wb_data_t rd_data;
	wb_data_t dat_q;
	logic     vcdl_pulse_q;
	logic     vcdl_enable_q;
	logic     train_disable_q;
	bitsel_t  bit_select_q;
	refsel_t  ref_select_q;
	logic     ref_select_wr_q;

	// Request seen, first cycle only.
	assign req = wb_cyc_i & wb_stb_i;
	assign acc = req & ~ack_q;
	assign wr_stb = acc & wb_we_i;

	////////////////////////////////////////
	// Read mux.
	////////////////////////////////////////

	always_comb begin
		rd_data = '0;
		case (wb_adr_i)
			ADDR_DPCTRL: begin
				// Pulse bit self-clears, reads zero.
				rd_data[DPCTRL_CONT_BIT] = vcdl_enable_q;
			end
			ADDR_DPTRAINING: begin
				rd_data[DPTR_DIS_BIT] = train_disable_q;
				rd_data[DPTR_SEL_LSB +: BSEL_W] = bit_select_q;
				rd_data[DPTR_PAT_LSB +: PAT_W] = train.pattern;
			end
			ADDR_DPCOUNTER: begin
				rd_data[DPCNT_SEL_LSB +: REFSEL_W] = ref_select_q;
				rd_data[DPCNT_CNT_LSB +: CNT_W] = vcdl.ref_count;
			end
			ADDR_DPCLKQ: begin
				rd_data[NUM_REF-1:0] = vcdl.ref_q;
			end
			default: begin
				// Unmapped.
				rd_data = '0;
			end
		endcase
	end

	////////////////////////////////////////
	// Ack, read data and control fields.
	////////////////////////////////////////

	always_ff @(posedge SYSCLK or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ack_q           <= 1'b0;
			dat_q           <= '0;
			vcdl_pulse_q    <= 1'b0;
			vcdl_enable_q   <= 1'b0;
			train_disable_q <= 1'b0;
			bit_select_q    <= '0;
			ref_select_q    <= '0;
			ref_select_wr_q <= 1'b0;
		end else begin
			ack_q <= acc;
			// Strobes last one cycle.
			vcdl_pulse_q    <= 1'b0;
			ref_select_wr_q <= 1'b0;
			if (acc) begin
				dat_q <= rd_data;
			end
			if (wr_stb) begin
				case (wb_adr_i)
					ADDR_DPCTRL: begin
						vcdl_pulse_q  <= wb_dat_i[DPCTRL_PULSE_BIT];
						vcdl_enable_q <= wb_dat_i[DPCTRL_CONT_BIT];
					end
					ADDR_DPTRAINING: begin
						train_disable_q <= wb_dat_i[DPTR_DIS_BIT];
						bit_select_q    <= wb_dat_i[DPTR_SEL_LSB +: BSEL_W];
					end
					ADDR_DPCOUNTER: begin
						// Any write here restarts the count.
						ref_select_q    <= wb_dat_i[DPCNT_SEL_LSB +: REFSEL_W];
						ref_select_wr_q <= 1'b1;
					end
					default: begin
					end
				endcase
			end
		end
	end

	assign wb_ack_o = ack_q;
	assign wb_dat_o = dat_q;

	assign train.train_disable = train_disable_q;
	assign train.bit_select    = bit_select_q;
	assign vcdl.vcdl_pulse     = vcdl_pulse_q;
	assign vcdl.vcdl_enable    = vcdl_enable_q;
	assign vcdl.ref_select     = ref_select_q;
	assign vcdl.ref_select_wr  = ref_select_wr_q;

endmodule

/* rtl/dp_train_capture.sv */
`timescale 1ns/1ns

module dp_train_capture import dp_pkg::*; #(
	parameter int NUM_CH  = 2,
	parameter int NUM_BIT = 12
) (
	input  logic                            SYSCLK,
	input  logic                            arst_n_i,
	input  logic [NUM_CH*NUM_BIT*NIB_W-1:0] ch_data_i,
	input  logic                            valid_i,
	input  logic                            sync_i,
	dp_train_if.capture                     train
);

	// One training latch per data bit.
	pattern_t              latch [NUM_CH][NUM_BIT];
	pattern_t              sel_pat;
	pattern_t              pattern_q;
	logic [BSEL_BIT_W-1:0] sel_bit;
	logic [BSEL_CH_W-1:0]  sel_ch;
	logic                  cap_en;

	// Capture only valid data with training on.
	assign cap_en = valid_i & ~train.train_disable;

	////////////////////////////////////////
	// Per-bit latches.
	////////////////////////////////////////

	for (genvar c = 0; c < NUM_CH; c++) begin : g_ch
		for (genvar b = 0; b < NUM_BIT; b++) begin : g_bit
			// Nibble position of this bit in the flat bus.
			localparam int LSB = (c * NUM_BIT + b) * NIB_W;

			always_ff @(posedge SYSCLK or negedge arst_n_i) begin
				if (!arst_n_i) begin
					latch[c][b] <= '0;
				end else if (cap_en) begin
					// Sync marks the first nibble of the pair.
					if (sync_i) begin
						latch[c][b][PAT_W-1 -: NIB_W] <= ch_data_i[LSB +: NIB_W];
					end else begin
						latch[c][b][NIB_W-1:0] <= ch_data_i[LSB +: NIB_W];
					end
				end
			end
		end
	end

	////////////////////////////////////////
	// Selected pattern.
	////////////////////////////////////////

	assign sel_bit = train.bit_select[BSEL_BIT_W-1:0];
	assign sel_ch  = train.bit_select[BSEL_W-1 -: BSEL_CH_W];

	// Out-of-range channel or bit gives zero.
	always_comb begin
		sel_pat = '0;
		for (int c = 0; c < NUM_CH; c++) begin
			for (int b = 0; b < NUM_BIT; b++) begin
				if (sel_ch == c && sel_bit == b) begin
					sel_pat = latch[c][b];
				end
			end
		end
	end

	// Pattern freezes while training is off.
	always_ff @(posedge SYSCLK or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pattern_q <= '0;
		end else if (!train.train_disable) begin
			pattern_q <= sel_pat;
		end
	end

	assign train.pattern = pattern_q;

endmodule

/* rtl/dp_vcdl_refclk.sv */
`timescale 1ns/1ns

module dp_vcdl_refclk import dp_pkg::*; #(
	parameter int NUM_REF = 2
) (
	input  logic               SYSCLK,
	input  logic               arst_n_i,
	input  logic               sync_i,
	input  logic [NUM_REF-1:0] refclk_i,
	output logic               vcdl_o,
	dp_vcdl_if.clk             vcdl
);

	logic               pulse_mem;
	logic               vcdl_q;
	logic [NUM_REF-1:0] ref_meta;
	logic [NUM_REF-1:0] ref_sync;
	logic [NUM_REF-1:0] ref_prev;
	logic               sel_rise;
	refcnt_t            count_q;

	////////////////////////////////////////
	// VCDL strobe.
	////////////////////////////////////////

	always_ff @(posedge SYSCLK or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pulse_mem <= 1'b0;
			vcdl_q    <= 1'b0;
		end else begin
			// Pending single pulse, a new request beats sync.
			if (vcdl.vcdl_pulse) begin
				pulse_mem <= 1'b1;
			end else if (sync_i) begin
				pulse_mem <= 1'b0;
			end
			// One cycle after sync.
			vcdl_q <= sync_i & (vcdl.vcdl_enable | pulse_mem);
		end
	end

	assign vcdl_o = vcdl_q;

	////////////////////////////////////////
	// Refclk monitor.
	////////////////////////////////////////

	// Rising edge of the selected synchronized refclk.
	always_comb begin
		sel_rise = 1'b0;
		for (int i = 0; i < NUM_REF; i++) begin
			if (vcdl.ref_select == i) begin
				sel_rise = ref_sync[i] & ~ref_prev[i];
			end
		end
	end

	always_ff @(posedge SYSCLK or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ref_meta <= '0;
			ref_sync <= '0;
			ref_prev <= '0;
			count_q  <= '0;
		end else begin
			// Two-flop synchronizer, then one more stage for edge detect.
			ref_meta <= refclk_i;
			ref_sync <= ref_meta;
			ref_prev <= ref_sync;
			if (vcdl.ref_select_wr) begin
				count_q <= '0;
			end else if (sel_rise && count_q != '1) begin
				// Saturates at full scale.
				count_q <= count_q + 1'b1;
			end
		end
	end

	assign vcdl.ref_count = count_q;
	assign vcdl.ref_q     = ref_sync;

endmodule

/* rtl/dp_top.sv */
`timescale 1ns/1ns

module dp_top import dp_pkg::*; #(
	parameter int NUM_CH  = 2,
	parameter int NUM_BIT = 12,
	parameter int NUM_REF = 2
) (
	input  logic                            SYSCLK,
	input  logic                            arst_n_i,
	// Wishbone classic slave.
	input  logic                            wb_cyc_i,
	input  logic                            wb_stb_i,
	input  logic                            wb_we_i,
	input  wb_addr_t                        wb_adr_i,
	input  wb_data_t                        wb_dat_i,
	output wb_data_t                        wb_dat_o,
	output logic                            wb_ack_o,
	// Deserialized data and framing.
	input  logic [NUM_CH*NUM_BIT*NIB_W-1:0] ch_data_i,
	input  logic                            valid_i,
	input  logic                            sync_i,
	// Reference clocks.
	input  logic [NUM_REF-1:0]              refclk_i,
	output logic                            vcdl_o,
	output logic                            train_on_o
);

	dp_train_if train_if ();
	dp_vcdl_if #(.NUM_REF(NUM_REF)) vcdl_if ();

	// Register block, status from both side blocks.
	dp_regs #(
		.NUM_CH  (NUM_CH),
		.NUM_BIT (NUM_BIT),
		.NUM_REF (NUM_REF)
	) u_regs (
		.SYSCLK   (SYSCLK),
		.arst_n_i (arst_n_i),
		.wb_cyc_i (wb_cyc_i),
		.wb_stb_i (wb_stb_i),
		.wb_we_i  (wb_we_i),
		.wb_adr_i (wb_adr_i),
		.wb_dat_i (wb_dat_i),
		.wb_dat_o (wb_dat_o),
		.wb_ack_o (wb_ack_o),
		.train    (train_if.regs),
		.vcdl     (vcdl_if.regs)
	);

	// Training capture.
	dp_train_capture #(
		.NUM_CH  (NUM_CH),
		.NUM_BIT (NUM_BIT)
	) u_train (
		.SYSCLK    (SYSCLK),
		.arst_n_i  (arst_n_i),
		.ch_data_i (ch_data_i),
		.valid_i   (valid_i),
		.sync_i    (sync_i),
		.train     (train_if.capture)
	);

	// VCDL strobe and refclk monitor.
	dp_vcdl_refclk #(
		.NUM_REF (NUM_REF)
	) u_vcdl (
		.SYSCLK   (SYSCLK),
		.arst_n_i (arst_n_i),
		.sync_i   (sync_i),
		.refclk_i (refclk_i),
		.vcdl_o   (vcdl_o),
		.vcdl     (vcdl_if.clk)
	);

	// High while training is disabled.
	assign train_on_o = train_if.train_disable;

endmodule

/* tb/dp_top_sva.sv */
`timescale 1ns/1ns

module dp_top_sva (
	input logic SYSCLK,
	input logic arst_n_i,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_ack_o,
	input logic sync_i,
	input logic vcdl_o
);

	////////////////////////////////////////
	// Wishbone.
	////////////////////////////////////////

	// Ack is one cycle wide.
	a_ack_single: assert property (@(posedge SYSCLK) disable iff (!arst_n_i)
		wb_ack_o |=> !wb_ack_o)
		else $error("wb_ack_o high for two cycles in a row");

	// Ack only after a request.
	a_ack_req: assert property (@(posedge SYSCLK) disable iff (!arst_n_i)
		wb_ack_o |-> $past(wb_cyc_i & wb_stb_i))
		else $error("wb_ack_o without a request in the cycle before");

	////////////////////////////////////////
	// VCDL.
	////////////////////////////////////////

	// Strobe is one cycle behind sync.
	a_vcdl_sync: assert property (@(posedge SYSCLK) disable iff (!arst_n_i)
		vcdl_o |-> $past(sync_i))
		else $error("vcdl_o high without sync_i in the cycle before");

endmodule

bind dp_top dp_top_sva u_sva (
	.SYSCLK   (SYSCLK),
	.arst_n_i (arst_n_i),
	.wb_cyc_i (wb_cyc_i),
	.wb_stb_i (wb_stb_i),
	.wb_ack_o (wb_ack_o),
	.sync_i   (sync_i),
	.vcdl_o   (vcdl_o)
);

/* tb/tb_dp_top.sv */
`timescale 1ns/1ns

module tb_dp_top import dp_pkg::*; ();

	localparam int NUM_CH  = 2;
	localparam int NUM_BIT = 12;
	localparam int NUM_REF = 2;
	localparam int DATA_W  = NUM_CH * NUM_BIT * NIB_W;
	// Longest test is the saturation run, about 4600 cycles.
	localparam int CYCLE_LIMIT = 20000;

	logic                SYSCLK;
	logic                arst_n_i;
	logic                wb_cyc_i;
	logic                wb_stb_i;
	logic                wb_we_i;
	wb_addr_t            wb_adr_i;
	wb_data_t            wb_dat_i;
	wb_data_t            wb_dat_o;
	logic                wb_ack_o;
	logic [DATA_W-1:0]   ch_data_i;
	logic                valid_i;
	logic                sync_i;
	logic [NUM_REF-1:0]  refclk_i;
	logic                vcdl_o;
	logic                train_on_o;

	// Reference model state.
	pattern_t lat_m [NUM_CH][NUM_BIT];
	logic     dis_m;
	logic     pm_m;
	int       n_errors;
	int       n_checks;
	int       cycles;

	dp_top #(
		.NUM_CH  (NUM_CH),
		.NUM_BIT (NUM_BIT),
		.NUM_REF (NUM_REF)
	) uut (
		.SYSCLK     (SYSCLK),
		.arst_n_i   (arst_n_i),
		.wb_cyc_i   (wb_cyc_i),
		.wb_stb_i   (wb_stb_i),
		.wb_we_i    (wb_we_i),
		.wb_adr_i   (wb_adr_i),
		.wb_dat_i   (wb_dat_i),
		.wb_dat_o   (wb_dat_o),
		.wb_ack_o   (wb_ack_o),
		.ch_data_i  (ch_data_i),
		.valid_i    (valid_i),
		.sync_i     (sync_i),
		.refclk_i   (refclk_i),
		.vcdl_o     (vcdl_o),
		.train_on_o (train_on_o)
	);

	////////////////////////////////////////
	// Clock and cycle limit.
	////////////////////////////////////////

	always #4 SYSCLK = ~SYSCLK;

	always @(posedge SYSCLK) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Something failed");
			$finish;
		end
	end

	////////////////////////////////////////
	// Helpers.
	////////////////////////////////////////

	task automatic check_value(input wb_data_t got, input wb_data_t exp, input string msg);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("[FAIL] %0t ns: %s, got %h, expected %h", $time, msg, got, exp);
		end
	endtask

	// Request held until ack, then one idle cycle.
	task automatic wb_write(input wb_addr_t adr, input wb_data_t dat);
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i  = 1'b1;
		wb_adr_i = adr;
		wb_dat_i = dat;
		do
			@(negedge SYSCLK);
		while (!wb_ack_o);
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i  = 1'b0;
		@(negedge SYSCLK);
	endtask

	// Read data is taken while ack is high.
	task automatic wb_read(input wb_addr_t adr, output wb_data_t dat);
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i  = 1'b0;
		wb_adr_i = adr;
		do
			@(negedge SYSCLK);
		while (!wb_ack_o);
		dat = wb_dat_o;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		@(negedge SYSCLK);
	endtask

	// Random data, valid and sync; the model tracks the latches.
	task automatic drive_training(input int n);
		logic [NIB_W-1:0] nib;
		for (int i = 0; i < n; i++) begin
			ch_data_i = {$urandom, $urandom, $urandom};
			valid_i   = ($urandom_range(0, 3) != 0);
			sync_i    = ($urandom_range(0, 1) != 0);
			if (valid_i && !dis_m) begin
				for (int c = 0; c < NUM_CH; c++) begin
					for (int b = 0; b < NUM_BIT; b++) begin
						nib = ch_data_i[(c * NUM_BIT + b) * NIB_W +: NIB_W];
						if (sync_i)
							lat_m[c][b][7:4] = nib;
						else
							lat_m[c][b][3:0] = nib;
					end
				end
			end
			@(negedge SYSCLK);
		end
		valid_i = 1'b0;
		sync_i  = 1'b0;
	endtask

	// Walks every select, out of range ones included.
	task automatic check_patterns();
		wb_data_t rd;
		pattern_t exp;
		for (int c = 0; c <= NUM_CH; c++) begin
			for (int b = 0; b < 16; b++) begin
				wb_write(ADDR_DPTRAINING, wb_data_t'((c * 16 + b) << DPTR_SEL_LSB));
				dis_m = 1'b0;
				exp = (c < NUM_CH && b < NUM_BIT) ? lat_m[c][b] : '0;
				wb_read(ADDR_DPTRAINING, rd);
				check_value({24'd0, rd[7:0]}, {24'd0, exp},
					$sformatf("pattern ch %0d bit %0d", c, b));
			end
		end
	endtask

	// Random syncs; checks vcdl_o every cycle against the model.
	task automatic run_sync(input int n, input logic cont, output int highs, output int syncs);
		logic exp_v;
		exp_v = 1'b0;
		highs = 0;
		syncs = 0;
		for (int i = 0; i < n; i++) begin
			check_value({31'd0, vcdl_o}, {31'd0, exp_v}, "vcdl_o");
			if (vcdl_o)
				highs++;
			sync_i = (i == 3) || ($urandom_range(0, 3) == 0);
			if (sync_i)
				syncs++;
			exp_v = sync_i & (cont | pm_m);
			if (sync_i)
				pm_m = 1'b0;
			@(negedge SYSCLK);
		end
		check_value({31'd0, vcdl_o}, {31'd0, exp_v}, "vcdl_o last");
		if (vcdl_o)
			highs++;
		sync_i = 1'b0;
	endtask

	// Levels of 2 or more cycles; counts rising edges of one refclk.
	task automatic refclk_run(input int sel, input int segs, input logic flip, output int rises);
		logic [NUM_REF-1:0] nv;
		int                 hold;
		rises = 0;
		for (int s = 0; s < segs; s++) begin
			nv   = flip ? ~refclk_i : NUM_REF'($urandom);
			hold = flip ? 2 : int'($urandom_range(2, 5));
			if (nv[sel] && !refclk_i[sel])
				rises++;
			refclk_i = nv;
			repeat (hold) @(negedge SYSCLK);
		end
	endtask

	////////////////////////////////////////
	// Test sequence.
	////////////////////////////////////////

	initial begin
		wb_data_t rd;
		wb_data_t wd;
		wb_addr_t adr;
		int       highs;
		int       syncs;
		int       rises;
		int       sel;
		pattern_t frozen;
		void'($urandom(98221));
		SYSCLK    = 1'b0;
		arst_n_i  = 1'b0;
		wb_cyc_i  = 1'b0;
		wb_stb_i  = 1'b0;
		wb_we_i   = 1'b0;
		wb_adr_i  = '0;
		wb_dat_i  = '0;
		ch_data_i = '0;
		valid_i   = 1'b0;
		sync_i    = 1'b0;
		refclk_i  = '0;
		dis_m     = 1'b0;
		pm_m      = 1'b0;
		n_errors  = 0;
		n_checks  = 0;
		cycles    = 0;
		for (int c = 0; c < NUM_CH; c++)
			for (int b = 0; b < NUM_BIT; b++)
				lat_m[c][b] = '0;
		repeat (16) @(negedge SYSCLK);
		arst_n_i = 1'b1;
		@(negedge SYSCLK);
		check_value({29'd0, wb_ack_o, vcdl_o, train_on_o}, '0, "outputs after reset");

		// Register readback, read-only fields masked.
		for (int i = 0; i < 30; i++) begin
			adr = wb_addr_t'($urandom_range(0, 2));
			wd  = $urandom;
			wb_write(adr, wd);
			wb_read(adr, rd);
			case (adr)
				ADDR_DPCTRL:
					check_value(rd, wd & 32'h0000_0002, "DPCTRL readback");
				ADDR_DPTRAINING: begin
					check_value(rd & 32'hFFFF_FF00, wd & 32'h807F_0000, "DPTRAINING readback");
					check_value({31'd0, train_on_o}, {31'd0, wd[31]}, "train_on_o");
				end
				default:
					check_value(rd & 32'hFFFF_FC00, wd & 32'h000F_0000, "DPCOUNTER readback");
			endcase
		end
		for (int a = 4; a < 16; a++) begin
			wb_read(wb_addr_t'(a), rd);
			check_value(rd, '0, $sformatf("unmapped address %0d", a));
		end
		wb_write(ADDR_DPCTRL, '0);
		wb_write(ADDR_DPCOUNTER, '0);
		wb_write(ADDR_DPTRAINING, '0);

		// Training capture.
		drive_training(200);
		repeat (4) @(negedge SYSCLK);
		check_patterns();

		// Training disable freezes pattern and latches.
		sel = int'($urandom_range(0, NUM_CH - 1)) * 16 + int'($urandom_range(0, NUM_BIT - 1));
		wb_write(ADDR_DPTRAINING, wb_data_t'(sel << DPTR_SEL_LSB));
		frozen = lat_m[sel / 16][sel % 16];
		wb_write(ADDR_DPTRAINING, 32'h8000_0000 | wb_data_t'(sel << DPTR_SEL_LSB));
		dis_m = 1'b1;
		drive_training(100);
		repeat (4) @(negedge SYSCLK);
		check_value({31'd0, train_on_o}, 32'd1, "train_on_o while disabled");
		wb_read(ADDR_DPTRAINING, rd);
		check_value({24'd0, rd[7:0]}, {24'd0, frozen}, "frozen pattern");
		wb_write(ADDR_DPTRAINING, 32'h8000_0000 | wb_data_t'((sel ^ 1) << DPTR_SEL_LSB));
		wb_read(ADDR_DPTRAINING, rd);
		check_value({24'd0, rd[7:0]}, {24'd0, frozen}, "frozen pattern after select");
		check_patterns();
		check_value({31'd0, train_on_o}, '0, "train_on_o after enable");

		// Single VCDL pulse, then continuous.
		wb_write(ADDR_DPCTRL, 32'h0000_0001);
		pm_m = 1'b1;
		run_sync(40, 1'b0, highs, syncs);
		check_value(highs, 32'd1, "single pulse count");
		wb_write(ADDR_DPCTRL, 32'h0000_0002);
		run_sync(40, 1'b1, highs, syncs);
		check_value(highs, syncs, "continuous pulse count");
		wb_write(ADDR_DPCTRL, '0);

		// Refclk counter per select, then saturation.
		for (int s = 0; s <= NUM_REF; s++) begin
			sel = (s == NUM_REF) ? 0 : s;
			wb_write(ADDR_DPCOUNTER, wb_data_t'(sel << DPCNT_SEL_LSB));
			refclk_run(sel, (s == NUM_REF) ? 2300 : 60, s == NUM_REF, rises);
			repeat (4) @(negedge SYSCLK);
			wb_read(ADDR_DPCOUNTER, rd);
			check_value(rd, wb_data_t'((sel << DPCNT_SEL_LSB) | (rises > 1023 ? 1023 : rises)),
				$sformatf("refclk %0d count", sel));
			wb_read(ADDR_DPCLKQ, rd);
			check_value(rd, wb_data_t'(refclk_i), "DPCLKQ levels");
			wb_write(ADDR_DPCOUNTER, wb_data_t'(sel << DPCNT_SEL_LSB));
			wb_read(ADDR_DPCOUNTER, rd);
			check_value(rd, wb_data_t'(sel << DPCNT_SEL_LSB), "count after clear");
		end

		$display("Checks run: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

/* tb.f */
rtl/dp_pkg.sv
rtl/dp_ctrl_if.sv
rtl/dp_regs.sv
rtl/dp_train_capture.sv
rtl/dp_vcdl_refclk.sv
rtl/dp_top.sv
tb/dp_top_sva.sv
tb/tb_dp_top.sv

/* Makefile */
TOP = tb_dp_top

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tb.f \
		-Mdir obj_dir -o V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log
